//--- Bender.yml
package:
  name: codec_init

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/codec_pkg.sv
      - hdl/codec_reg_table.sv
      - hdl/codec_init_seq.sv
      - hdl/i2c_master.sv
      - hdl/codec_init_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/codec_init_chk.sv
      - dv/codec_init_tb.sv

//--- dv/codec_init_chk.sv
/*
 * Codec loader protocol checker.
 * Bound into the top level, watches the strobes, start/done pairing
 * and the idle bus.
 */
`timescale 1ns/1ps

module codec_init_chk import codec_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     busy,
    input logic     cfg_done,
    input logic     cfg_error,
    input logic     xfer_start,
    input logic     xfer_done,
    input i2c_rsp_t rsp,
    input logic     scl,
    input logic     sda_oe
);

    int   fail_cnt = 0;   // assertion failures so far
    logic in_flight;      // master between start and done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            in_flight <= 1'b0;
        else if (xfer_start)
            in_flight <= 1'b1;
        else if (xfer_done)
            in_flight <= 1'b0;
    end

    // ----------------------------------------
    // properties
    // ----------------------------------------
    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(cfg_done && cfg_error))
    else begin
        fail_cnt++;
        $error("cfg_done and cfg_error high together");
    end

    a_done_once: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_done |=> !cfg_done)
    else begin
        fail_cnt++;
        $error("cfg_done longer than one cycle");
    end

    a_error_once: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_error |=> !cfg_error)
    else begin
        fail_cnt++;
        $error("cfg_error longer than one cycle");
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_start |-> !in_flight)
    else begin
        fail_cnt++;
        $error("xfer_start while the master is busy");
    end

    // bus parked whenever the loader is idle
    a_idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> (scl && !sda_oe))
    else begin
        fail_cnt++;
        $error("bus not idle while busy is low");
    end

    a_nack_error: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer_done && !rsp.ack_ok) |=> cfg_error)
    else begin
        fail_cnt++;
        $error("nack not followed by cfg_error");
    end

endmodule

bind codec_init_top codec_init_chk codec_init_chk_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .cfg_done   (cfg_done),
    .cfg_error  (cfg_error),
    .xfer_start (xfer_start),
    .xfer_done  (xfer_done),
    .rsp        (rsp),
    .scl        (scl),
    .sda_oe     (sda_oe)
);

//--- dv/codec_init_tb.sv
/*
 * Codec loader testbench.
 * Open-drain I2C slave model plus directed tests of the power-up
 * table, settle pause, NACK abort and restart.
 */
`timescale 1ns/1ps
`include "codec_cfg.svh"

module codec_init_tb import codec_pkg::*; ();

    localparam int CLK_NS    = 40;
    localparam int WAIT_CLKS = 6000;   // per wait loop

    logic clk;
    logic rst_n;
    logic restart;
    logic sda_line;                    // resolved bus level
    logic scl, sda_oe, busy, cfg_done, cfg_error;

    int          err_cnt;
    int          done_pulses;
    int          error_pulses;
    logic        busy_at_strobe;       // busy seen with the last strobe
    logic [31:0] lcg_state;

    // ----------------------------------------
    // slave model state
    // ----------------------------------------
    i2c_xfer_t  wr_q[$];               // completed writes
    logic [7:0] dev_q[$];              // address byte of each
    time        start_t[$];
    time        stop_t[$];
    logic [7:0] rx[3];
    logic [7:0] shreg;
    int         bit_cnt, byte_cnt, start_cnt, cur_xfer;
    int         nack_xfer, nack_byte;  // -1 acks everything
    logic       in_xfer, nacked, slave_low;

    assign sda_line = ~(sda_oe | slave_low);   // pulled up, low when either side drives

    codec_init_top codec_init_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .restart   (restart),
        .sda_in    (sda_line),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .busy      (busy),
        .cfg_done  (cfg_done),
        .cfg_error (cfg_error)
    );

    always #(CLK_NS / 2) clk = ~clk;

    always @(negedge clk) begin
        if (cfg_done)
            done_pulses++;
        if (cfg_error)
            error_pulses++;
    end

    // SDA falling under high SCL marks a start
    always @(negedge sda_line) begin
        if (scl === 1'b1) begin
            in_xfer  = 1'b1;
            nacked   = 1'b0;
            bit_cnt  = 0;
            byte_cnt = 0;
            cur_xfer = start_cnt;
            start_cnt++;
            start_t.push_back($time);
        end
    end

    // SDA rising under high SCL marks a stop
    always @(posedge sda_line) begin
        if (scl === 1'b1 && in_xfer) begin
            in_xfer = 1'b0;
            stop_t.push_back($time);
            if (byte_cnt == 3 && !nacked) begin
                wr_q.push_back(i2c_xfer_t'{rx[1], rx[2]});
                dev_q.push_back(rx[0]);
            end
        end
    end

    always @(posedge scl) begin
        if (in_xfer) begin
            if (bit_cnt < 8) begin
                shreg = {shreg[6:0], sda_line};   // msb first
                bit_cnt++;
            end else begin
                bit_cnt = 0;                      // ack clock done
                byte_cnt++;
            end
        end
    end

    // ack after the 8th bit and release after the ack clock
    always @(negedge scl) begin
        if (in_xfer && bit_cnt == 8) begin
            rx[byte_cnt] = shreg;
            slave_low    = !(cur_xfer == nack_xfer && byte_cnt == nack_byte);
            nacked       = nacked | !slave_low;
        end else begin
            slave_low = 1'b0;
        end
    end

    // ----------------------------------------
    // compare tasks and helpers
    // ----------------------------------------
    task automatic check_xfer(input string name, input i2c_xfer_t got, input i2c_xfer_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // register/value pairs as the codec should receive them
    function automatic i2c_xfer_t expected_entry(input int idx);
        logic [2:0] wl;
        logic [7:0] vol;
        case (`CODEC_WORD_LEN)
            16:      wl = 3'd3;
            18:      wl = 3'd2;
            20:      wl = 3'd1;
            32:      wl = 3'd4;
            default: wl = 3'd0;   // 24 and unknown lengths
        endcase
        vol = 8'(`CODEC_VOLUME);
        case (idx)
            0: return '{8'h00, 8'h80};
            1: return '{8'h00, 8'h00};
            2: return '{8'h01, 8'h58};
            3: return '{8'h02, 8'hF3};
            4: return '{8'h08, 8'h00};
            5: return '{8'h17, {2'b00, wl, 3'b000}};   // word length code
            6: return '{8'h18, 8'h02};
            7: return '{8'h2E, vol};
            8: return '{8'h2F, vol};
            9: return '{8'h02, 8'h00};
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic pulse_restart();
        @(negedge clk);
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
    endtask

    task automatic arm_slave(input int k, input int b);
        wr_q.delete();
        dev_q.delete();
        start_t.delete();
        stop_t.delete();
        start_cnt    = 0;
        nack_xfer    = k;
        nack_byte    = b;
        done_pulses  = 0;
        error_pulses = 0;
    endtask

    task automatic wait_strobe(output logic got_done, output logic got_error);
        int n;
        n         = 0;
        got_done  = 1'b0;
        got_error = 1'b0;
        while (!got_done && !got_error && n < WAIT_CLKS) begin
            @(negedge clk);
            got_done       = cfg_done;
            got_error      = cfg_error;
            busy_at_strobe = busy;
            n++;
        end
        if (!got_done && !got_error) begin
            $display("timeout: no cfg_done or cfg_error within %0d clocks", WAIT_CLKS);
            err_cnt++;
        end
        @(negedge clk);   // one clock past the strobe
    endtask

    task automatic wait_writes(input int n);
        int c;
        c = 0;
        while (wr_q.size() < n && c < WAIT_CLKS) begin
            @(negedge clk);
            c++;
        end
        if (wr_q.size() < n) begin
            $display("timeout: slave saw only %0d of %0d writes", wr_q.size(), n);
            err_cnt++;
        end
    endtask

    task automatic verify_table_writes(input int n);
        check_bit($sformatf("write count %0d, expected %0d", wr_q.size(), n),
                  wr_q.size() == n, 1'b1);
        for (int i = 0; i < n && i < wr_q.size(); i++) begin
            check_xfer($sformatf("write[%0d]", i), wr_q[i], expected_entry(i));
            check_bit($sformatf("dev byte[%0d] %h is 0x10 write", i, dev_q[i]),
                      dev_q[i] == {7'h10, 1'b0}, 1'b1);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_powerup_sequence();
        logic got_done, got_error;
        wait_strobe(got_done, got_error);
        check_bit("cfg_done", got_done, 1'b1);
        verify_table_writes(REG_NUM);   // entries 5, 7, 8 from config
    endtask

    task automatic test_done_strobe();
        check_bit("busy with cfg_done", busy_at_strobe, 1'b0);
        check_bit("cfg_error pulsed", error_pulses != 0, 1'b0);
        check_bit("single cfg_done pulse", done_pulses == 1, 1'b1);
        repeat (3) @(negedge clk);
        check_bit("scl idle", scl, 1'b1);
        check_bit("sda_oe idle", sda_oe, 1'b0);
    endtask

    task automatic test_settle_delay();
        time gap;
        check_bit("ten starts and stops",
                  start_t.size() == REG_NUM && stop_t.size() == REG_NUM, 1'b1);
        for (int i = 0; i + 1 < start_t.size() && i < stop_t.size(); i++) begin
            gap = start_t[i+1] - stop_t[i];
            if (i == 1)
                check_bit($sformatf("settle gap %0t long enough", gap),
                          gap >= `CODEC_SETTLE_CYCLES * CLK_NS, 1'b1);
            else
                check_bit($sformatf("gap %0d of %0t below settle", i, gap),
                          gap < `CODEC_SETTLE_CYCLES * CLK_NS, 1'b1);
        end
    endtask

    task automatic test_nack_abort();
        int   k, b;
        logic got_done, got_error;
        k = int'((lcg_next() >> 16) % 32'd10);
        b = int'((lcg_next() >> 16) % 32'd3);
        $display("nack on byte %0d of write %0d", b, k);
        arm_slave(k, b);
        pulse_restart();
        wait_strobe(got_done, got_error);
        check_bit("cfg_error", got_error, 1'b1);
        check_bit("cfg_done", got_done, 1'b0);
        check_bit("single cfg_error pulse", error_pulses == 1, 1'b1);
        check_bit("cfg_done pulsed", done_pulses != 0, 1'b0);
        check_bit("busy with cfg_error", busy_at_strobe, 1'b0);
        verify_table_writes(k);
    endtask

    task automatic test_restart();
        logic got_done, got_error;
        arm_slave(-1, -1);
        pulse_restart();
        check_bit("busy after restart", busy, 1'b1);
        wait_writes(3);
        pulse_restart();                // lands mid-sequence and must be ignored
        wait_strobe(got_done, got_error);
        check_bit("cfg_done", got_done, 1'b1);
        check_bit("cfg_error", got_error, 1'b0);
        check_bit("single cfg_done pulse", done_pulses == 1, 1'b1);
        verify_table_writes(REG_NUM);
    endtask

    initial begin
        int total;
        clk       = 1'b0;
        rst_n     = 1'b0;
        restart   = 1'b0;
        slave_low = 1'b0;
        in_xfer   = 1'b0;
        err_cnt   = 0;
        lcg_state = 32'h941a88f4;
        arm_slave(-1, -1);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        test_powerup_sequence();
        test_done_strobe();
        test_settle_delay();
        test_nack_abort();
        test_restart();
        total = err_cnt + codec_init_top_inst.codec_init_chk_inst.fail_cnt;
        $display("errors: %0d checks, %0d assertions", err_cnt,
                 codec_init_top_inst.codec_init_chk_inst.fail_cnt);
        if (total == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
hdl/codec_pkg.sv
hdl/codec_reg_table.sv
hdl/codec_init_seq.sv
hdl/i2c_master.sv
hdl/codec_init_top.sv
dv/codec_init_chk.sv
dv/codec_init_tb.sv

//--- hdl/codec_init_seq.sv
/*
 * Codec init sequencer.
 * Waits out the power-up delay, steps the register table through the
 * I2C master, pauses after the soft reset and ends with done or error.
 */
`timescale 1ns/1ps
`include "codec_cfg.svh"

module codec_init_seq import codec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       restart,      // rerun request, honoured only when idle
    input  logic       xfer_done,    // master finished a write
    input  i2c_rsp_t   rsp,          // valid with xfer_done
    input  i2c_xfer_t  entry,        // table output for entry_idx
    output logic [3:0] entry_idx,    // next entry to issue
    output i2c_xfer_t  xfer,         // held for the master
    output logic       xfer_start,
    output logic       busy,
    output logic       cfg_done,
    output logic       cfg_error
);

    localparam logic [15:0] PWR_LAST    = 16'(`CODEC_POWERUP_CYCLES - 1);
    localparam logic [15:0] SETTLE_LAST = 16'(`CODEC_SETTLE_CYCLES - 2);
    localparam logic [3:0]  SETTLE_IDX  = 4'd2;   // pause before this entry
    localparam logic [3:0]  LAST_IDX    = 4'(REG_NUM);

    typedef enum logic [2:0] {
        S_PWR,      // power-up delay
        S_ISSUE,    // strobe xfer_start
        S_WAIT,     // transfer in flight
        S_SETTLE,   // soft reset settle pause
        S_IDLE
    } seq_state_t;

    seq_state_t  state;
    logic [15:0] dly_cnt;   // shared by power-up and settle
    logic        issue_go;  // moving into S_ISSUE this clock
    logic        ack_next;  // acked write with more entries to go

    assign xfer_start = (state == S_ISSUE);

    assign ack_next = (state == S_WAIT) && xfer_done && rsp.ack_ok &&
                      (entry_idx != LAST_IDX);

    assign issue_go = ((state == S_PWR) && (dly_cnt == PWR_LAST)) ||
                      ((state == S_SETTLE) && (dly_cnt == SETTLE_LAST)) ||
                      (ack_next && (entry_idx != SETTLE_IDX));

    // ----------------------------------------
    // control FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_PWR;
            dly_cnt   <= '0;
            entry_idx <= '0;
            busy      <= 1'b0;
            cfg_done  <= 1'b0;
            cfg_error <= 1'b0;
        end else begin
            cfg_done  <= 1'b0;   // strobes last one clock
            cfg_error <= 1'b0;
            dly_cnt   <= '0;     // only the pause states count
            if (issue_go) begin
                state     <= S_ISSUE;
                entry_idx <= entry_idx + 4'd1;
            end
            case (state)
                S_PWR: begin
                    busy <= 1'b1;
                    if (!issue_go)
                        dly_cnt <= dly_cnt + 16'd1;
                end
                S_ISSUE: state <= S_WAIT;   // one-cycle strobe
                S_WAIT: begin
                    if (xfer_done) begin
                        if (!rsp.ack_ok) begin            // nack aborts
                            state     <= S_IDLE;
                            busy      <= 1'b0;
                            cfg_error <= 1'b1;
                        end else if (entry_idx == LAST_IDX) begin
                            state    <= S_IDLE;
                            busy     <= 1'b0;
                            cfg_done <= 1'b1;
                        end else if (entry_idx == SETTLE_IDX) begin
                            state <= S_SETTLE;            // codec reset recovery
                        end
                    end
                end
                S_SETTLE: begin
                    if (!issue_go)
                        dly_cnt <= dly_cnt + 16'd1;
                end
                S_IDLE: begin
                    if (restart) begin
                        state     <= S_PWR;
                        entry_idx <= '0;
                        busy      <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // payload captured as the strobe goes out
    always_ff @(posedge clk) begin
        if (issue_go)
            xfer <= entry;
    end

endmodule

//--- hdl/codec_init_top.sv
/*
 * Codec power-up loader top.
 * Sequencer, register table and I2C master joined by wires.
 */
`timescale 1ns/1ps

module codec_init_top import codec_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic restart,     // rerun strobe
    input  logic sda_in,
    output logic scl,
    output logic sda_oe,      // high pulls SDA low
    output logic busy,
    output logic cfg_done,    // strobe
    output logic cfg_error    // strobe
);

    // ----------------------------------------
    // internal links
    // ----------------------------------------
    logic [3:0] entry_idx;
    i2c_xfer_t  entry;       // table lookup
    i2c_xfer_t  xfer;        // held write
    logic       xfer_start;
    logic       xfer_done;
    i2c_rsp_t   rsp;

    codec_init_seq codec_init_seq_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .restart    (restart),
        .xfer_done  (xfer_done),
        .rsp        (rsp),
        .entry      (entry),
        .entry_idx  (entry_idx),
        .xfer       (xfer),
        .xfer_start (xfer_start),
        .busy       (busy),
        .cfg_done   (cfg_done),
        .cfg_error  (cfg_error)
    );

    codec_reg_table codec_reg_table_inst (
        .entry_idx (entry_idx),
        .entry     (entry)
    );

    i2c_master i2c_master_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .xfer_start (xfer_start),
        .xfer       (xfer),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .xfer_done  (xfer_done),
        .rsp        (rsp)
    );

endmodule

//--- hdl/codec_pkg.sv
/*
 * Codec loader types.
 * One register write as it travels from table to I2C engine,
 * the engine's response, and the table size.
 */
package codec_pkg;

    // ----------------------------------------
    // table size
    // ----------------------------------------
    localparam int unsigned REG_NUM = 10;   // entries written after power-up

    // ----------------------------------------
    // transfer and response
    // ----------------------------------------

    // one register write, device address is added by the master
    typedef struct packed {
        logic [7:0] reg_addr;   // codec register
        logic [7:0] reg_data;   // value to write
    } i2c_xfer_t;

    // result of one three-byte write
    typedef struct packed {
        logic ack_ok;           // all three bytes acked
    } i2c_rsp_t;

endpackage

//--- hdl/codec_reg_table.sv
/*
 * Codec register table.
 * Combinational index to register/value lookup for the power-up
 * sequence, word length and volume taken from the build config.
 */
`timescale 1ns/1ps
`include "codec_cfg.svh"

module codec_reg_table import codec_pkg::*; (
    input  logic [3:0] entry_idx,   // table position
    output i2c_xfer_t  entry        // register/value pair
);

    // ----------------------------------------
    // word length to the codec's 3-bit code
    // ----------------------------------------
    localparam logic [2:0] WL_CODE =
        (`CODEC_WORD_LEN == 16) ? 3'd3 :
        (`CODEC_WORD_LEN == 18) ? 3'd2 :
        (`CODEC_WORD_LEN == 20) ? 3'd1 :
        (`CODEC_WORD_LEN == 24) ? 3'd0 :
        (`CODEC_WORD_LEN == 32) ? 3'd4 : 3'd0;   // unknown length falls back to 24

    localparam logic [7:0] VOL = 8'(`CODEC_VOLUME);

    always_comb begin
        entry = '0;   // out of range reads as zero
        case (entry_idx)
            4'd0: entry = '{reg_addr: 8'h00, reg_data: 8'h80};   // soft reset on
            4'd1: entry = '{reg_addr: 8'h00, reg_data: 8'h00};   // soft reset off
            4'd2: entry = '{reg_addr: 8'h01, reg_data: 8'h58};   // chip control 2
            4'd3: entry = '{reg_addr: 8'h02, reg_data: 8'hF3};   // power down sections
            4'd4: entry = '{reg_addr: 8'h08, reg_data: 8'h00};   // slave mode
            4'd5: entry = '{reg_addr: 8'h17, reg_data: {2'b00, WL_CODE, 3'b000}};
            4'd6: entry = '{reg_addr: 8'h18, reg_data: 8'h02};   // dac fs ratio
            4'd7: entry = '{reg_addr: 8'h2E, reg_data: VOL};     // lout1 volume
            4'd8: entry = '{reg_addr: 8'h2F, reg_data: VOL};     // rout1 volume
            4'd9: entry = '{reg_addr: 8'h02, reg_data: 8'h00};   // power everything up
            default: entry = '0;
        endcase
    end

endmodule

//--- hdl/i2c_master.sv
/*
 * Write-only I2C master.
 * Sends start, device address, register and data bytes with an ACK
 * slot after each, then stop. Open-drain style, sda_oe pulls SDA low.
 */
`timescale 1ns/1ps
`include "codec_cfg.svh"

module i2c_master import codec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      xfer_start,   // only while idle
    input  i2c_xfer_t xfer,
    input  logic      sda_in,       // resolved bus level
    output logic      scl,
    output logic      sda_oe,       // 1 drives SDA low
    output logic      xfer_done,    // one-cycle strobe
    output i2c_rsp_t  rsp
);

    localparam int DIV   = `CODEC_I2C_DIV;
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    typedef enum logic [1:0] {
        M_IDLE,
        M_START,    // SDA low with SCL high, one SCL period
        M_BIT,      // 8 data bits plus ack slot, per byte
        M_STOP      // SCL up then SDA released
    } mst_state_t;

    mst_state_t       state;
    logic [CNT_W-1:0] div_cnt;
    logic             half;       // 0 low half, 1 high half
    logic [3:0]       bit_cnt;    // 8 is the ack slot
    logic [1:0]       byte_cnt;   // addr, reg, data
    logic [7:0]       shift_q;    // msb first
    i2c_xfer_t        xfer_q;
    logic             ack_ok;
    logic             active;
    logic             tick;       // end of a half period
    logic             sda_slot;   // one clock into the low half

    assign active   = (state != M_IDLE);
    assign tick     = active && (div_cnt == CNT_W'(DIV - 1));
    assign sda_slot = ((state == M_BIT) || (state == M_STOP)) && !half &&
                      (div_cnt == '0);

    // ----------------------------------------
    // half-period divider
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            div_cnt <= '0;
        else if (!active || tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ----------------------------------------
    // bit/byte FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= M_IDLE;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            half      <= 1'b0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            ack_ok    <= 1'b0;
            xfer_done <= 1'b0;
            rsp       <= '0;
        end else begin
            xfer_done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (xfer_start) begin
                        state    <= M_START;
                        sda_oe   <= 1'b1;    // start, SDA falls under high SCL
                        half     <= 1'b0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        ack_ok   <= 1'b1;
                    end
                end
                M_START: begin
                    if (tick) begin
                        half <= ~half;
                        if (half) begin
                            scl   <= 1'b0;
                            state <= M_BIT;
                        end
                    end
                end
                M_BIT: begin
                    if (sda_slot)   // release for ack, else drive the bit
                        sda_oe <= (bit_cnt == 4'd8) ? 1'b0 : ~shift_q[7];
                    if (tick) begin
                        half <= ~half;
                        if (!half) begin
                            scl <= 1'b1;
                        end else begin
                            scl <= 1'b0;
                            if (bit_cnt == 4'd8) begin
                                bit_cnt <= '0;
                                if (sda_in) begin           // nack, sampled at SCL high
                                    ack_ok <= 1'b0;
                                    state  <= M_STOP;
                                end else if (byte_cnt == 2'd2) begin
                                    state <= M_STOP;
                                end else begin
                                    byte_cnt <= byte_cnt + 2'd1;
                                end
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                    end
                end
                M_STOP: begin
                    if (sda_slot)
                        sda_oe <= 1'b1;              // SDA low under low SCL
                    if (tick) begin
                        half <= ~half;
                        if (!half) begin
                            scl <= 1'b1;
                        end else begin
                            sda_oe     <= 1'b0;      // stop, SDA rises under high SCL
                            state      <= M_IDLE;
                            xfer_done  <= 1'b1;
                            rsp.ack_ok <= ack_ok;
                        end
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // byte shifter and held payload
    always_ff @(posedge clk) begin
        if ((state == M_IDLE) && xfer_start) begin
            shift_q <= {`CODEC_DEV_ADDR, 1'b0};   // write bit
            xfer_q  <= xfer;
        end else if ((state == M_BIT) && tick && half) begin
            if (bit_cnt == 4'd8)
                shift_q <= (byte_cnt == 2'd0) ? xfer_q.reg_addr : xfer_q.reg_data;
            else
                shift_q <= {shift_q[6:0], 1'b0};
        end
    end

endmodule

//--- include/codec_cfg.svh
/*
 * Codec loader build configuration.
 * Device address, power-up and settle delays, I2C divider,
 * audio word length and output volume.
 */
`ifndef CODEC_CFG_SVH
`define CODEC_CFG_SVH

// ----------------------------------------
// bus and timing
// ----------------------------------------
`define CODEC_DEV_ADDR        7'h10   // 7-bit slave address, CE pin low
`define CODEC_POWERUP_CYCLES  64      // clocks from reset release to first write
`define CODEC_SETTLE_CYCLES   200     // pause after the soft reset release
`define CODEC_I2C_DIV         4       // clocks per SCL half period, at least 2

// ----------------------------------------
// audio setup
// ----------------------------------------
`define CODEC_WORD_LEN        16      // one of 16, 18, 20, 24, 32
`define CODEC_VOLUME          30      // output volume, 0 to 33

`endif
